// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbGbaVideo
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hw/displayRegs.sv ====
`timescale 1ns/1ps

module displayRegs (
    input  logic       GCLK,
    input  logic       reset,
    input  logic [7:0] SW,
    input  logic       lineStart,
    input  logic       lineDone,
    output logic       lineAccept,
    output logic       bitmapMode,
    output logic       mosaicOn,
    output logic       fadeOn,
    output logic [3:0] fadeLevel
);

    // high from an accepted start until the matching lineDone
    logic busy;

    // starts that arrive mid-line are dropped
    assign lineAccept = lineStart && !busy;

    always_ff @(posedge GCLK) begin
        if (reset) begin
            busy       <= 1'b0;
            bitmapMode <= 1'b0;
            mosaicOn   <= 1'b0;
            fadeOn     <= 1'b0;
            fadeLevel  <= 4'd0;
        end else begin
            if (lineAccept) begin
                busy <= 1'b1;
            end else if (lineDone) begin
                busy <= 1'b0;
            end
            // settings frozen for the whole line
            if (lineAccept) begin
                bitmapMode <= SW[0];
                mosaicOn   <= SW[5];
                fadeOn     <= SW[6];
                fadeLevel  <= SW[4:1];
            end
        end
    end

endmodule : displayRegs

// ==== hw/fadeOutput.sv ====
`timescale 1ns/1ps

module fadeOutput (
    input  logic        GCLK,
    input  logic        reset,
    input  logic        popValid,
    input  logic [14:0] popPixel,
    input  logic        fadeOn,
    input  logic [3:0]  fadeLevel,
    output logic        popReady,
    output logic [3:0]  VGA_R,
    output logic [3:0]  VGA_G,
    output logic [3:0]  VGA_B,
    output logic        pixelValid,
    output logic        lineDone
);

    import gbaVideoPkg::*;

    logic              pop;
    logic [xWidth-1:0] pixCount;

    // darken one channel toward black, then keep the top four bits
    function automatic logic [3:0] fadeChannel(input logic [4:0] c, input logic on,
                                               input logic [3:0] level);
        logic [8:0] scaled;
        logic [4:0] faded;
        scaled = c * level;
        faded  = on ? c - scaled[8:4] : c;
        return faded[4:1];
    endfunction

    assign pop = popValid && popReady;

    always_ff @(posedge GCLK) begin
        if (reset) begin
            popReady   <= 1'b0;
            pixelValid <= 1'b0;
            lineDone   <= 1'b0;
            pixCount   <= '0;
        end else begin
            // half rate sink, keeps the buffer under pressure
            popReady   <= !popReady;
            pixelValid <= pop;
            lineDone   <= pop && (pixCount == xWidth'(lineWidth - 1));
            if (pop) begin
                pixCount <= pixCount + 1'b1;
            end
        end
    end

    always_ff @(posedge GCLK) begin
        if (pop) begin
            VGA_R <= fadeChannel(popPixel[4:0], fadeOn, fadeLevel);
            VGA_G <= fadeChannel(popPixel[9:5], fadeOn, fadeLevel);
            VGA_B <= fadeChannel(popPixel[14:10], fadeOn, fadeLevel);
        end
    end

endmodule : fadeOutput

// ==== hw/gbaVideoPkg.sv ====
package gbaVideoPkg;

    // pixels per scanline
    localparam int lineWidth = 32;

    // pixel buffer entries, also the credit count after reset
    localparam int fifoDepth = 8;

    // must hold the value fifoDepth
    localparam int creditWidth = 4;

    // position along the line
    localparam int xWidth = 5;

    // write address shared by video memory and palette
    localparam int memAddrWidth = 5;

    // direct color word, GBA bit order
    typedef struct packed {
        logic       unused;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } bgr555_t;

    // text background screen entry
    typedef struct packed {
        logic [3:0] palBank;
        logic       vflip;
        logic       hflip;
        logic [9:0] tileNum;
    } screenEntry_t;

    // one video memory word, read as a color in bitmap mode
    // and as a screen entry in character mode
    typedef union packed {
        bgr555_t      color;
        screenEntry_t entry;
    } vramWord_u;

endpackage : gbaVideoPkg

// ==== hw/gbaVideoTop.sv ====
`timescale 1ns/1ps

module gbaVideoTop (
    input  logic                                GCLK,
    input  logic                                reset,
    input  logic [7:0]                          SW,
    input  logic                                lineStart,
    input  logic                                memWe,
    input  logic                                memSel,
    input  logic [gbaVideoPkg::memAddrWidth-1:0] memAddr,
    input  logic [15:0]                         memData,
    output logic [3:0]                          VGA_R,
    output logic [3:0]                          VGA_G,
    output logic [3:0]                          VGA_B,
    output logic                                pixelValid,
    output logic                                lineDone
);

    logic        lineAccept;
    logic        bitmapMode;
    logic        mosaicOn;
    logic        fadeOn;
    logic [3:0]  fadeLevel;

    // producer to buffer
    logic        pushValid;
    logic [14:0] pushPixel;
    logic        creditReturn;

    // buffer to consumer
    logic        popValid;
    logic [14:0] popPixel;
    logic        popReady;

    displayRegs u_displayRegs (
        .GCLK       (GCLK),
        .reset      (reset),
        .SW         (SW),
        .lineStart  (lineStart),
        .lineDone   (lineDone),
        .lineAccept (lineAccept),
        .bitmapMode (bitmapMode),
        .mosaicOn   (mosaicOn),
        .fadeOn     (fadeOn),
        .fadeLevel  (fadeLevel)
    );

    lineFetch u_lineFetch (
        .GCLK         (GCLK),
        .reset        (reset),
        .lineAccept   (lineAccept),
        .bitmapMode   (bitmapMode),
        .mosaicOn     (mosaicOn),
        .memWe        (memWe),
        .memSel       (memSel),
        .memAddr      (memAddr),
        .memData      (memData),
        .creditReturn (creditReturn),
        .pushValid    (pushValid),
        .pushPixel    (pushPixel)
    );

    pixelFifo u_pixelFifo (
        .GCLK         (GCLK),
        .reset        (reset),
        .pushValid    (pushValid),
        .pushPixel    (pushPixel),
        .popReady     (popReady),
        .popValid     (popValid),
        .popPixel     (popPixel),
        .creditReturn (creditReturn)
    );

    fadeOutput u_fadeOutput (
        .GCLK       (GCLK),
        .reset      (reset),
        .popValid   (popValid),
        .popPixel   (popPixel),
        .fadeOn     (fadeOn),
        .fadeLevel  (fadeLevel),
        .popReady   (popReady),
        .VGA_R      (VGA_R),
        .VGA_G      (VGA_G),
        .VGA_B      (VGA_B),
        .pixelValid (pixelValid),
        .lineDone   (lineDone)
    );

endmodule : gbaVideoTop

// ==== hw/lineFetch.sv ====
`timescale 1ns/1ps

module lineFetch (
    input  logic                                GCLK,
    input  logic                                reset,
    input  logic                                lineAccept,
    input  logic                                bitmapMode,
    input  logic                                mosaicOn,
    input  logic                                memWe,
    input  logic                                memSel,
    input  logic [gbaVideoPkg::memAddrWidth-1:0] memAddr,
    input  logic [15:0]                         memData,
    input  logic                                creditReturn,
    output logic                                pushValid,
    output logic [14:0]                         pushPixel
);

    import gbaVideoPkg::*;

    vramWord_u vram [lineWidth];
    // 16 palette colors, BGR555 without the spare bit
    logic [14:0] palette [16];

    logic                   active;
    logic [xWidth-1:0]      x;
    logic [xWidth-1:0]      rdAddr;
    logic [creditWidth-1:0] credits;
    logic                   issue;

    // first pipeline stage
    logic      s1Valid;
    vramWord_u rdWord;

    // a read goes out only with a credit in hand
    assign issue = active && (credits != '0);

    // mosaic snaps every position to the first of its group of four
    assign rdAddr = mosaicOn ? {x[xWidth-1:2], 2'b00} : x;

    always_ff @(posedge GCLK) begin
        if (memWe && !memSel) begin
            vram[memAddr] <= memData;
        end
        if (memWe && memSel) begin
            palette[memAddr[3:0]] <= memData[14:0];
        end
    end

    always_ff @(posedge GCLK) begin
        if (reset) begin
            active <= 1'b0;
            x      <= '0;
        end else if (lineAccept) begin
            active <= 1'b1;
            x      <= '0;
        end else if (issue) begin
            x <= x + 1'b1;
            if (x == xWidth'(lineWidth - 1)) begin
                active <= 1'b0;
            end
        end
    end

    // in-flight reads already hold their credit
    always_ff @(posedge GCLK) begin
        if (reset) begin
            credits <= creditWidth'(fifoDepth);
        end else begin
            credits <= credits + creditWidth'(creditReturn) - creditWidth'(issue);
        end
    end

    always_ff @(posedge GCLK) begin
        if (reset) begin
            s1Valid   <= 1'b0;
            pushValid <= 1'b0;
        end else begin
            s1Valid   <= issue;
            pushValid <= s1Valid;
        end
    end

    always_ff @(posedge GCLK) begin
        rdWord <= vram[rdAddr];
        if (bitmapMode) begin
            pushPixel <= {rdWord.color.blue, rdWord.color.green, rdWord.color.red};
        end else begin
            // flip and bank bits have no effect here
            pushPixel <= palette[rdWord.entry.tileNum[3:0]];
        end
    end

endmodule : lineFetch

// ==== hw/pixelFifo.sv ====
`timescale 1ns/1ps

module pixelFifo (
    input  logic        GCLK,
    input  logic        reset,
    input  logic        pushValid,
    input  logic [14:0] pushPixel,
    input  logic        popReady,
    output logic        popValid,
    output logic [14:0] popPixel,
    output logic        creditReturn
);

    import gbaVideoPkg::*;

    logic [14:0] mem [fifoDepth];

    logic [$clog2(fifoDepth)-1:0]   rdPtr;
    logic [$clog2(fifoDepth)-1:0]   wrPtr;
    logic [$clog2(fifoDepth+1)-1:0] count;
    logic                           pop;

    assign popValid = (count != '0);
    assign popPixel = mem[rdPtr];
    assign pop      = popValid && popReady;

    // every freed slot goes straight back to the producer
    assign creditReturn = pop;

    always_ff @(posedge GCLK) begin
        if (pushValid) begin
            mem[wrPtr] <= pushPixel;
        end
    end

    // no full check, the producer never pushes without a credit
    always_ff @(posedge GCLK) begin
        if (reset) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + ($bits(count))'(pushValid) - ($bits(count))'(pop);
        end
    end

endmodule : pixelFifo

// ==== src.f ====
hw/gbaVideoPkg.sv
hw/displayRegs.sv
hw/lineFetch.sv
hw/pixelFifo.sv
hw/fadeOutput.sv
hw/gbaVideoTop.sv
testbench/pixelFifo_sva.sv
testbench/tbGbaVideo.sv

// ==== testbench/pixelFifo_sva.sv ====
`timescale 1ns/1ps

module pixelFifoSva (
    input logic                                         GCLK,
    input logic                                         reset,
    input logic                                         pushValid,
    input logic                                         popValid,
    input logic                                         popReady,
    input logic                                         creditReturn,
    input logic [$clog2(gbaVideoPkg::fifoDepth)-1:0]   rdPtr,
    input logic [$clog2(gbaVideoPkg::fifoDepth)-1:0]   wrPtr,
    input logic [$clog2(gbaVideoPkg::fifoDepth+1)-1:0] count
);

    import gbaVideoPkg::*;

    // credits keep a full buffer from ever seeing a push
    noPushWhenFull: assert property (@(posedge GCLK) disable iff (reset)
        (count == fifoDepth) |-> !pushValid)
        else $error("push into a full pixel buffer");

    // pointers must show data whenever an entry leaves
    noPopWhenEmpty: assert property (@(posedge GCLK) disable iff (reset)
        (popValid && popReady) |-> (rdPtr != wrPtr) || (count == fifoDepth))
        else $error("pop from an empty pixel buffer");

    // one credit for each step of the read pointer
    creditMatchesPop: assert property (@(posedge GCLK) disable iff (reset)
        $past(creditReturn) == (rdPtr != $past(rdPtr)))
        else $error("creditReturn differs from the pop condition");

    countInRange: assert property (@(posedge GCLK) disable iff (reset)
        count <= fifoDepth)
        else $error("buffer occupancy %0d above depth", count);

endmodule : pixelFifoSva

bind pixelFifo pixelFifoSva u_pixelFifoSva (
    .GCLK         (GCLK),
    .reset        (reset),
    .pushValid    (pushValid),
    .popValid     (popValid),
    .popReady     (popReady),
    .creditReturn (creditReturn),
    .rdPtr        (rdPtr),
    .wrPtr        (wrPtr),
    .count        (count)
);

// ==== testbench/tbGbaVideo.sv ====
`timescale 1ns/1ps

module tbGbaVideo;

    import gbaVideoPkg::*;

    localparam int numLines    = 26;
    localparam int resetCycles = 16;
    localparam int clkPeriod   = 40;
    // four cycles per pixel covers the half-rate sink and pipeline fill
    localparam int watchdogNs  = numLines * lineWidth * 4 * clkPeriod
                               + resetCycles * clkPeriod + 50000;

    logic                    GCLK = 1'b0;
    logic                    reset;
    logic [7:0]              SW;
    logic                    lineStart;
    logic                    memWe;
    logic                    memSel;
    logic [memAddrWidth-1:0] memAddr;
    logic [15:0]             memData;
    logic [3:0]              VGA_R;
    logic [3:0]              VGA_G;
    logic [3:0]              VGA_B;
    logic                    pixelValid;
    logic                    lineDone;

    // model copies of video memory and palette
    vramWord_u   vramModel [lineWidth];
    logic [14:0] palModel [16];

    // expected {R, G, B} of the line in progress, in output order
    logic [11:0] expQ [$];
    logic [11:0] expPix;
    string       testName = "reset";
    int          pixIdx = 0;
    int          doneCount = 0;
    int          mismatchErrors = 0;
    int          flowErrors = 0;

    gbaVideoTop u_gbaVideoTop (
        .GCLK       (GCLK),
        .reset      (reset),
        .SW         (SW),
        .lineStart  (lineStart),
        .memWe      (memWe),
        .memSel     (memSel),
        .memAddr    (memAddr),
        .memData    (memData),
        .VGA_R      (VGA_R),
        .VGA_G      (VGA_G),
        .VGA_B      (VGA_B),
        .pixelValid (pixelValid),
        .lineDone   (lineDone)
    );

    always #(clkPeriod / 2) GCLK = ~GCLK;

    initial begin
        #(watchdogNs);
        $display("timeout: the run did not finish within %0d ns", watchdogNs);
        $display("Done: errors found");
        $finish;
    end

    // fade toward black by level/16, then drop the low bit
    function automatic logic [3:0] fadeAndNarrow(input int c, input bit fade, input int level);
        int v;
        v = fade ? c - (c * level) / 16 : c;
        return 4'(v / 2);
    endfunction

    task automatic fillMem(input logic sel, input int words);
        logic [15:0] data;
        for (int a = 0; a < words; a++) begin
            data = 16'($urandom);
            @(posedge GCLK);
            #2;
            memWe   = 1'b1;
            memSel  = sel;
            memAddr = memAddrWidth'(a);
            memData = data;
            if (sel) begin
                palModel[a] = data[14:0];
            end else begin
                vramModel[a] = data;
            end
        end
        @(posedge GCLK);
        #2;
        memWe = 1'b0;
    endtask

    task automatic buildExpected(input logic [7:0] sw);
        vramWord_u   w;
        logic [14:0] c;
        int          addr;
        for (int p = 0; p < lineWidth; p++) begin
            // mosaic groups of four share the first word
            addr = sw[5] ? (p / 4) * 4 : p;
            w    = vramModel[addr];
            if (sw[0]) begin
                c = {w.color.blue, w.color.green, w.color.red};
            end else begin
                c = palModel[w.entry.tileNum[3:0]];
            end
            expQ.push_back({fadeAndNarrow(int'(c[4:0]), sw[6], int'(sw[4:1])),
                            fadeAndNarrow(int'(c[9:5]), sw[6], int'(sw[4:1])),
                            fadeAndNarrow(int'(c[14:10]), sw[6], int'(sw[4:1]))});
        end
    endtask

    task automatic runLine(input string name, input logic [7:0] sw, input bit midStart);
        bit seen;
        int cycles;
        testName = name;
        buildExpected(sw);
        @(posedge GCLK);
        #2;
        SW        = sw;
        lineStart = 1'b1;
        @(posedge GCLK);
        #2;
        lineStart = 1'b0;
        if (midStart) begin
            // a second start and new switches while the line runs
            repeat (24) @(posedge GCLK);
            #2;
            SW        = ~sw;
            lineStart = 1'b1;
            @(posedge GCLK);
            #2;
            lineStart = 1'b0;
        end
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < lineWidth * 4 + 16) begin
            @(negedge GCLK);
            seen = lineDone;
            cycles++;
        end
        if (!seen) begin
            flowErrors++;
            $display("%s: lineDone did not arrive within %0d cycles", name, cycles);
        end
        @(posedge GCLK);
        if (expQ.size() != 0) begin
            flowErrors++;
            $display("%s: line ended with %0d pixels not delivered", name, expQ.size());
            expQ.delete();
        end
        // idle long enough for a wrongly accepted line to show up
        if (midStart) begin
            repeat (lineWidth * 3) @(posedge GCLK);
        end
    endtask

    always @(negedge GCLK) begin
        if (!reset) begin
            if (pixelValid) begin
                if (expQ.size() == 0) begin
                    flowErrors++;
                    $display("%s: pixel output when no pixel was expected", testName);
                end else begin
                    expPix = expQ.pop_front();
                    if ({VGA_R, VGA_G, VGA_B} != expPix) begin
                        mismatchErrors++;
                        $display("error %s pixel %0d: expected %h actual %h",
                                 testName, pixIdx, expPix, {VGA_R, VGA_G, VGA_B});
                    end
                end
                pixIdx++;
            end
            if (lineDone) begin
                // lineDone belongs with the last pixel of the line
                if (pixIdx != lineWidth) begin
                    flowErrors++;
                    $display("%s: lineDone came after %0d pixels instead of %0d",
                             testName, pixIdx, lineWidth);
                end
                doneCount++;
                pixIdx = 0;
            end
        end
    end

    initial begin
        logic [7:0] sw;
        void'($urandom(33560));
        reset     = 1'b1;
        SW        = 8'd0;
        lineStart = 1'b0;
        memWe     = 1'b0;
        memSel    = 1'b0;
        memAddr   = '0;
        memData   = 16'd0;
        repeat (resetCycles) @(posedge GCLK);
        #2;
        reset = 1'b0;
        for (int i = 0; i < 3; i++) begin
            fillMem(1'b0, lineWidth);
            sw    = 8'($urandom);
            sw[0] = 1'b1;
            sw[5] = 1'b0;
            sw[6] = 1'b0;
            runLine("bitmap", sw, 1'b0);
        end
        // flip and bank bits stay random in the screen entries
        for (int i = 0; i < 3; i++) begin
            fillMem(1'b1, 16);
            fillMem(1'b0, lineWidth);
            sw    = 8'($urandom);
            sw[0] = 1'b0;
            sw[5] = 1'b0;
            sw[6] = 1'b0;
            runLine("character", sw, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            fillMem(1'b0, lineWidth);
            sw    = 8'($urandom);
            sw[0] = i[0];
            sw[5] = 1'b1;
            sw[6] = 1'b0;
            runLine("mosaic", sw, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            fillMem(1'b0, lineWidth);
            sw    = 8'($urandom);
            sw[6] = 1'b1;
            runLine("fade", sw, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            runLine("midLine", 8'($urandom), 1'b1);
        end
        for (int i = 0; i < 6; i++) begin
            runLine("backToBack", 8'($urandom), 1'b0);
        end
        repeat (lineWidth * 2) @(posedge GCLK);
        if (doneCount != numLines) begin
            flowErrors++;
            $display("error lineCount: expected %0d actual %0d", numLines, doneCount);
        end
        $display("errors: %0d pixel mismatches, %0d flow errors", mismatchErrors, flowErrors);
        if (mismatchErrors + flowErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tbGbaVideo
